/* axi_bridge.f */
source/brg_pkg.sv
source/axi_pkg.sv
source/brg_in_slice.sv
source/wdata_fifo.sv
source/raw_addr_fifo.sv
source/axi_master_ctrl.sv
source/axi_bridge_top.sv
test/axi_bridge_checker.sv
test/tb_axi_bridge.sv

/* run_sim.sh */
#!/bin/sh
# build and run the AXI bridge testbench, the log decides the result
rm -f build.log sim.log
verilator --binary --timing --top-module tb_axi_bridge -f axi_bridge.f -o sim_axi_bridge \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_axi_bridge > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

/* source/axi_bridge_top.sv */
// bridge top level, intake slices, write data FIFO, pending write FIFO, control
module axi_bridge_top #(
  parameter int P_WD_DEPTH  = 4,
  parameter int P_RAW_DEPTH = 4
) (
  input  logic                clk_core,
  input  logic                rst_x,
  // internal command port
  input  logic                i_brg_req,
  input  brg_pkg::brg_cmd_t   i_brg_cmd,
  output logic                o_brg_ack,
  // internal write data port
  input  logic                i_brg_wdvalid,
  input  brg_pkg::brg_wdat_t  i_brg_wdat,
  output logic                o_brg_wack,
  // read return
  output logic                o_brg_rdvalid,
  output brg_pkg::brg_rdat_t  o_brg_rdat,
  // AXI write address
  output logic                o_awvalid,
  output axi_pkg::axi_addr_t  o_aw,
  input  logic                i_awready,
  // AXI write data
  output logic                o_wvalid,
  output axi_pkg::axi_w_t     o_w,
  input  logic                i_wready,
  // AXI write response
  input  logic                i_bvalid,
  output logic                o_bready,
  // AXI read address
  output logic                o_arvalid,
  output axi_pkg::axi_addr_t  o_ar,
  input  logic                i_arready,
  // AXI read data
  input  logic                i_rvalid,
  input  axi_pkg::axi_r_t     i_r,
  output logic                o_rready
);
  import brg_pkg::*;

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////
  // command slice to control
  logic      w_cmd_valid;
  brg_cmd_t  w_cmd;
  logic      w_cmd_take;
  // data slice to write data FIFO
  logic      w_wd_valid;
  brg_wdat_t w_wd_slice;
  logic      w_wd_full;
  // write data FIFO to control
  logic      w_wd_empty;
  brg_wdat_t w_wd_head;
  logic      w_wd_pop;
  // pending write tracking
  logic      w_raw_hit;
  logic      w_raw_full;
  logic      w_raw_push;

  // every B pops the pending write FIFO, never stalled
  assign o_bready = 1'b1;

  //////////////////////////////////////////////////
  // intake
  //////////////////////////////////////////////////
  brg_in_slice #(.T_PAYLOAD(brg_cmd_t)) u_cmd_slice (
    .clk_core (clk_core),
    .rst_x    (rst_x),
    .i_stb    (i_brg_req),
    .i_data   (i_brg_cmd),
    .o_ack    (o_brg_ack),
    .o_valid  (w_cmd_valid),
    .o_data   (w_cmd),
    .i_take   (w_cmd_take)
  );

  // held while the FIFO is full
  brg_in_slice #(.T_PAYLOAD(brg_wdat_t)) u_wd_slice (
    .clk_core (clk_core),
    .rst_x    (rst_x),
    .i_stb    (i_brg_wdvalid),
    .i_data   (i_brg_wdat),
    .o_ack    (o_brg_wack),
    .o_valid  (w_wd_valid),
    .o_data   (w_wd_slice),
    .i_take   (~w_wd_full)
  );

  wdata_fifo #(.P_WD_DEPTH(P_WD_DEPTH)) u_wd_fifo (
    .clk_core (clk_core),
    .rst_x    (rst_x),
    .i_push   (w_wd_valid),
    .i_wdat   (w_wd_slice),
    .o_full   (w_wd_full),
    .i_pop    (w_wd_pop),
    .o_wdat   (w_wd_head),
    .o_empty  (w_wd_empty)
  );

  // check and record against the command in the slice
  raw_addr_fifo #(.P_RAW_DEPTH(P_RAW_DEPTH)) u_raw_fifo (
    .clk_core     (clk_core),
    .rst_x        (rst_x),
    .i_push       (w_raw_push),
    .i_push_addr  (w_cmd.addr),
    .i_pop        (i_bvalid),
    .i_check_addr (w_cmd.addr),
    .o_hit        (w_raw_hit),
    .o_full       (w_raw_full)
  );

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  axi_master_ctrl u_ctrl (
    .clk_core      (clk_core),
    .rst_x         (rst_x),
    .i_cmd_valid   (w_cmd_valid),
    .i_cmd         (w_cmd),
    .o_cmd_take    (w_cmd_take),
    .i_wd_empty    (w_wd_empty),
    .i_wdat        (w_wd_head),
    .o_wd_pop      (w_wd_pop),
    .i_raw_hit     (w_raw_hit),
    .i_raw_full    (w_raw_full),
    .o_raw_push    (w_raw_push),
    .o_awvalid     (o_awvalid),
    .o_aw          (o_aw),
    .i_awready     (i_awready),
    .o_wvalid      (o_wvalid),
    .o_w           (o_w),
    .i_wready      (i_wready),
    .o_arvalid     (o_arvalid),
    .o_ar          (o_ar),
    .i_arready     (i_arready),
    .i_rvalid      (i_rvalid),
    .i_r           (i_r),
    .o_rready      (o_rready),
    .o_brg_rdvalid (o_brg_rdvalid),
    .o_brg_rdat    (o_brg_rdat)
  );

endmodule

/* source/axi_master_ctrl.sv */
// command issue to AW/AR, write burst sequencer, W drive, read return register
module axi_master_ctrl (
  input  logic               clk_core,
  input  logic               rst_x,
  // command slice
  input  logic               i_cmd_valid,
  input  brg_pkg::brg_cmd_t  i_cmd,
  output logic               o_cmd_take,
  // write data FIFO head
  input  logic               i_wd_empty,
  input  brg_pkg::brg_wdat_t i_wdat,
  output logic               o_wd_pop,
  // pending write tracking
  input  logic               i_raw_hit,
  input  logic               i_raw_full,
  output logic               o_raw_push,
  // AXI master
  output logic               o_awvalid,
  output axi_pkg::axi_addr_t o_aw,
  input  logic               i_awready,
  output logic               o_wvalid,
  output axi_pkg::axi_w_t    o_w,
  input  logic               i_wready,
  output logic               o_arvalid,
  output axi_pkg::axi_addr_t o_ar,
  input  logic               i_arready,
  input  logic               i_rvalid,
  input  axi_pkg::axi_r_t    i_r,
  output logic               o_rready,
  // read return
  output logic               o_brg_rdvalid,
  output brg_pkg::brg_rdat_t o_brg_rdat
);
  import brg_pkg::*;
  import axi_pkg::*;

  typedef enum logic {ST_IDLE = 1'b0, ST_BUSY = 1'b1} wstate_t;

  wstate_t              r_wstate;
  logic [BRG_LEN_W-1:0] r_beat_cnt;  // beats left in the burst
  logic [BRG_ID_W-1:0]  r_wid;       // id of the write in flight
  logic                 r_rdvalid;
  brg_rdat_t            r_rdat;
  logic                 w_idle;
  logic                 w_aw_hs;
  logic                 w_ar_hs;
  logic                 w_w_hs;
  logic                 w_wlast;
  logic [BRG_LEN_W-1:0] w_len_m1;
  axi_addr_t            w_req;

  //////////////////////////////////////////////////
  // command issue
  //////////////////////////////////////////////////
  assign w_idle = (r_wstate == ST_IDLE);
  // write waits for a free pending slot
  assign o_awvalid = w_idle & i_cmd_valid & i_cmd.rw & ~i_raw_full;
  // read waits while its address has a write without B
  assign o_arvalid = w_idle & i_cmd_valid & ~i_cmd.rw & ~i_raw_hit;
  assign w_aw_hs = o_awvalid & i_awready;
  assign w_ar_hs = o_arvalid & i_arready;
  // slice entry freed on either address handshake
  assign o_cmd_take = w_aw_hs | w_ar_hs;
  assign o_raw_push = w_aw_hs;

  // lengths above 16 beats do not fit AXI3
  assign w_len_m1 = i_cmd.len - 1'b1;

  // AW and AR carry the same fields, valid picks the channel
  always_comb begin
    w_req.id    = AXI_ID_W'(i_cmd.id);
    w_req.addr  = {i_cmd.addr, {(AXI_ADDR_W - BRG_ADDR_W){1'b0}}};
    w_req.len   = w_len_m1[AXI_LEN_W-1:0];
    w_req.size  = AXI_SIZE_4B;
    w_req.burst = AXI_BURST_INCR;
    w_req.cache = AXI_CACHE_DEV;
  end
  assign o_aw = w_req;
  assign o_ar = w_req;

  //////////////////////////////////////////////////
  // write sequencer
  //////////////////////////////////////////////////
  assign o_wvalid = (r_wstate == ST_BUSY) & ~i_wd_empty;
  assign w_w_hs   = o_wvalid & i_wready;
  assign w_wlast  = (r_beat_cnt == BRG_LEN_W'(1));
  assign o_wd_pop = w_w_hs;

  // busy from AW handshake until the last W handshake
  always_ff @(posedge clk_core or negedge rst_x) begin
    if (!rst_x) begin
      r_wstate   <= ST_IDLE;
      r_beat_cnt <= '0;
    end else begin
      case (r_wstate)
        ST_IDLE: begin
          if (w_aw_hs) begin
            r_wstate   <= ST_BUSY;
            r_beat_cnt <= i_cmd.len;
          end
        end
        ST_BUSY: begin
          if (w_w_hs) begin
            r_beat_cnt <= r_beat_cnt - 1'b1;
            if (w_wlast) r_wstate <= ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_core) begin
    if (w_aw_hs) r_wid <= i_cmd.id;
  end

  always_comb begin
    o_w.id   = AXI_ID_W'(r_wid);
    o_w.data = i_wdat.data;
    o_w.strb = i_wdat.be;
    o_w.last = w_wlast;
  end

  //////////////////////////////////////////////////
  // read return, one cycle behind R
  //////////////////////////////////////////////////
  assign o_rready = 1'b1;

  always_ff @(posedge clk_core or negedge rst_x) begin
    if (!rst_x) begin
      r_rdvalid <= 1'b0;
    end else begin
      r_rdvalid <= i_rvalid;
    end
  end

  // low id bits are the internal tag
  always_ff @(posedge clk_core) begin
    r_rdat.id   <= i_r.id[BRG_ID_W-1:0];
    r_rdat.data <= i_r.data;
    r_rdat.last <= i_r.last;
  end

  assign o_brg_rdvalid = r_rdvalid;
  assign o_brg_rdat    = r_rdat;

endmodule

/* source/axi_pkg.sv */
// AXI3 widths, fixed field codes, address, write and read channel structs
package axi_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int AXI_ID_W    = 4;
  localparam int AXI_ADDR_W  = 32;
  // AXI3 burst length field, up to 16 beats
  localparam int AXI_LEN_W   = 4;
  localparam int AXI_SIZE_W  = 3;
  localparam int AXI_BURST_W = 2;
  localparam int AXI_CACHE_W = 4;
  localparam int AXI_DATA_W  = 32;
  localparam int AXI_STRB_W  = AXI_DATA_W / 8;

  //////////////////////////////////////////////////
  // field codes
  //////////////////////////////////////////////////
  // 4 bytes per beat
  localparam logic [AXI_SIZE_W-1:0]  AXI_SIZE_4B    = 3'd2;
  // incrementing burst
  localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'd1;
  // device, non-bufferable
  localparam logic [AXI_CACHE_W-1:0] AXI_CACHE_DEV  = 4'd0;

  //////////////////////////////////////////////////
  // channel payloads
  //////////////////////////////////////////////////
  // shared by AW and AR
  typedef struct packed {
    logic [AXI_ID_W-1:0]    id;
    logic [AXI_ADDR_W-1:0]  addr;
    logic [AXI_LEN_W-1:0]   len;
    logic [AXI_SIZE_W-1:0]  size;
    logic [AXI_BURST_W-1:0] burst;
    logic [AXI_CACHE_W-1:0] cache;
  } axi_addr_t;

  // W beat, AXI3 still carries WID
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  // R beat, response code not used
  typedef struct packed {
    logic [AXI_ID_W-1:0]   id;
    logic [AXI_DATA_W-1:0] data;
    logic                  last;
  } axi_r_t;

endpackage

/* source/brg_in_slice.sv */
// one-entry strobe/ack holding register for any payload type
module brg_in_slice #(
  parameter type T_PAYLOAD = logic
) (
  input  logic     clk_core,
  input  logic     rst_x,
  // bus side, one-cycle strobe
  input  logic     i_stb,
  input  T_PAYLOAD i_data,
  output logic     o_ack,
  // consumer side
  output logic     o_valid,
  output T_PAYLOAD o_data,
  input  logic     i_take
);

  //////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////
  logic     r_full;
  T_PAYLOAD r_data;
  logic     w_accept;
  logic     w_release;

  // source only strobes while ack is high
  assign w_accept  = i_stb & ~r_full;
  // take has no effect on an empty entry
  assign w_release = r_full & i_take;

  // full flag, accept and release never coincide
  always_ff @(posedge clk_core or negedge rst_x) begin
    if (!rst_x) begin
      r_full <= 1'b0;
    end else if (w_accept) begin
      r_full <= 1'b1;
    end else if (w_release) begin
      r_full <= 1'b0;
    end
  end

  // payload capture
  always_ff @(posedge clk_core) begin
    if (w_accept) begin
      r_data <= i_data;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////
  // ack low from acceptance until the take
  assign o_ack   = ~r_full;
  // payload visible one cycle after the strobe
  assign o_valid = r_full;
  assign o_data  = r_data;

endmodule

/* source/brg_pkg.sv */
// internal bus widths, command struct, write beat struct, read beat struct
package brg_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  // word address, byte offset implied by bus width
  localparam int BRG_ADDR_W = 30;
  // burst length in beats, 1..16 used
  localparam int BRG_LEN_W  = 6;
  localparam int BRG_DATA_W = 32;
  localparam int BRG_BE_W   = BRG_DATA_W / 8;
  // requester tag
  localparam int BRG_ID_W   = 2;

  //////////////////////////////////////////////////
  // payloads
  //////////////////////////////////////////////////
  // one command from the internal bus
  typedef struct packed {
    logic [BRG_ID_W-1:0]   id;
    logic                  rw;    // 1 = write
    logic [BRG_ADDR_W-1:0] addr;
    logic [BRG_LEN_W-1:0]  len;
  } brg_cmd_t;

  // one write beat
  typedef struct packed {
    logic [BRG_BE_W-1:0]   be;
    logic [BRG_DATA_W-1:0] data;
  } brg_wdat_t;

  // one read beat back to the requester
  typedef struct packed {
    logic [BRG_ID_W-1:0]   id;
    logic [BRG_DATA_W-1:0] data;
    logic                  last;
  } brg_rdat_t;

endpackage

/* source/raw_addr_fifo.sv */
// pending write address FIFO with associative match on a read address
module raw_addr_fifo #(
  parameter int P_RAW_DEPTH = 4
) (
  input  logic                           clk_core,
  input  logic                           rst_x,
  // AW handshake records the word address
  input  logic                           i_push,
  input  logic [brg_pkg::BRG_ADDR_W-1:0] i_push_addr,
  // B response retires the oldest entry
  input  logic                           i_pop,
  // address of the command waiting in the slice
  input  logic [brg_pkg::BRG_ADDR_W-1:0] i_check_addr,
  output logic                           o_hit,
  output logic                           o_full
);
  import brg_pkg::*;

  localparam int PTR_W = (P_RAW_DEPTH > 1) ? $clog2(P_RAW_DEPTH) : 1;

  //////////////////////////////////////////////////
  // entries
  //////////////////////////////////////////////////
  logic [BRG_ADDR_W-1:0]  r_addr [P_RAW_DEPTH];
  logic [P_RAW_DEPTH-1:0] r_vld;
  logic [PTR_W-1:0]       r_wr_ptr;
  logic [PTR_W-1:0]       r_rd_ptr;
  logic [P_RAW_DEPTH-1:0] w_match;
  logic                   w_wr;
  logic                   w_rd;

  function automatic logic [PTR_W-1:0] f_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(P_RAW_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // every slot holds an outstanding write
  assign o_full = &r_vld;
  assign w_wr   = i_push & ~o_full;
  // B without a pending write is dropped
  assign w_rd   = i_pop & r_vld[r_rd_ptr];

  // valid bits and pointers
  // push needs a free slot, pop a valid one, so never the same slot
  always_ff @(posedge clk_core or negedge rst_x) begin
    if (!rst_x) begin
      r_vld    <= '0;
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (w_wr) begin
        r_vld[r_wr_ptr] <= 1'b1;
        r_wr_ptr        <= f_next(r_wr_ptr);
      end
      if (w_rd) begin
        r_vld[r_rd_ptr] <= 1'b0;
        r_rd_ptr        <= f_next(r_rd_ptr);
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (w_wr) r_addr[r_wr_ptr] <= i_push_addr;
  end

  //////////////////////////////////////////////////
  // hazard match
  //////////////////////////////////////////////////
  // only valid slots compare, empty FIFO never hits
  always_comb begin
    for (int i = 0; i < P_RAW_DEPTH; i++) begin
      w_match[i] = r_vld[i] & (r_addr[i] == i_check_addr);
    end
  end

  assign o_hit = |w_match;

endmodule

/* source/wdata_fifo.sv */
// write data FIFO, circular buffer with count, first word fall through
module wdata_fifo #(
  parameter int P_WD_DEPTH = 4
) (
  input  logic               clk_core,
  input  logic               rst_x,
  input  logic               i_push,
  input  brg_pkg::brg_wdat_t i_wdat,
  output logic               o_full,
  input  logic               i_pop,
  output brg_pkg::brg_wdat_t o_wdat,
  output logic               o_empty
);
  import brg_pkg::*;

  localparam int PTR_W = (P_WD_DEPTH > 1) ? $clog2(P_WD_DEPTH) : 1;
  localparam int CNT_W = $clog2(P_WD_DEPTH + 1);

  brg_wdat_t        r_mem [P_WD_DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;
  logic             w_wr;
  logic             w_rd;

  // pointer advance, wraps at depth
  function automatic logic [PTR_W-1:0] f_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(P_WD_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ignore push when full, pop when empty
  assign w_wr = i_push & ~o_full;
  assign w_rd = i_pop & ~o_empty;

  always_ff @(posedge clk_core or negedge rst_x) begin
    if (!rst_x) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_wr) r_wr_ptr <= f_next(r_wr_ptr);
      if (w_rd) r_rd_ptr <= f_next(r_rd_ptr);
      r_count <= r_count + CNT_W'(w_wr) - CNT_W'(w_rd);
    end
  end

  // storage
  always_ff @(posedge clk_core) begin
    if (w_wr) r_mem[r_wr_ptr] <= i_wdat;
  end

  // head beat drives W directly
  assign o_wdat  = r_mem[r_rd_ptr];
  assign o_full  = (r_count == CNT_W'(P_WD_DEPTH));
  assign o_empty = (r_count == '0);

endmodule

/* test/axi_bridge_checker.sv */
// bridge checker, shadow memory, reference functions, channel compares, counters
module axi_bridge_checker (
  input  logic               clk_core,
  input  logic               rst_x,
  // internal side, sampled on accepted handshakes
  input  logic               i_brg_req,
  input  brg_pkg::brg_cmd_t  i_brg_cmd,
  input  logic               i_brg_ack,
  input  logic               i_brg_wdvalid,
  input  brg_pkg::brg_wdat_t i_brg_wdat,
  input  logic               i_brg_wack,
  // AXI handshakes and payloads
  input  logic               i_aw_hs,
  input  axi_pkg::axi_addr_t i_aw,
  input  logic               i_w_hs,
  input  axi_pkg::axi_w_t    i_w,
  input  logic               i_ar_hs,
  input  axi_pkg::axi_addr_t i_ar,
  input  logic               i_rvalid,
  // held-high ready outputs
  input  logic               i_bready,
  input  logic               i_rready,
  // read return
  input  logic               i_brg_rdvalid,
  input  brg_pkg::brg_rdat_t i_brg_rdat,
  output int                 o_err_cnt,
  output int                 o_aw_cnt,
  output int                 o_wlast_cnt,
  output int                 o_ar_cnt,
  output logic               o_busy
);
  import brg_pkg::*;
  import axi_pkg::*;

  brg_cmd_t    cmd_q[$];
  brg_wdat_t   wd_q[$];
  brg_rdat_t   rd_q[$];
  logic [31:0] shadow [512];
  brg_cmd_t    cur_w;
  int          w_beat = 0;
  int          err_cnt = 0;
  int          aw_cnt = 0;
  int          wlast_cnt = 0;
  int          ar_cnt = 0;
  logic        rvalid_d = 1'b0;
  logic        busy = 1'b0;

  // same power-up contents as the slave memory
  function automatic logic [31:0] fill_word(input int a);
    return 32'hc3a50000 ^ (32'(a) * 32'h00010003);
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  // byte address, INCR, 4 byte beats, cache 0
  function automatic axi_addr_t expected_req(input brg_cmd_t c);
    axi_addr_t r;
    r.id    = {2'b00, c.id};
    r.addr  = 32'(c.addr) << 2;
    r.len   = 4'(c.len - 6'd1);
    r.size  = 3'd2;
    r.burst = 2'd1;
    r.cache = 4'd0;
    return r;
  endfunction

  // beat k of a read, from memory as of the AR
  function automatic brg_rdat_t expected_beat(input brg_cmd_t c, input int k);
    brg_rdat_t r;
    r.id   = c.id;
    r.data = shadow[9'(c.addr) + 9'(k)];
    r.last = (k == int'(c.len) - 1);
    return r;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input brg_wdat_t wd);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (wd.be[b]) begin
        r[8*b +: 8] = wd.data[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR: %s at %0t", msg, $time);
    err_cnt++;
  endtask

  task automatic report_mismatch(input string sig, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("Mismatch %s got %h exp %h at %0t", sig, got, exp, $time);
    err_cnt++;
  endtask

  //////////////////////////////////////////////////
  // compare on every rising edge
  //////////////////////////////////////////////////
  always @(posedge clk_core) begin
    brg_cmd_t  c;
    brg_wdat_t wd;
    axi_w_t    ew;
    brg_rdat_t er;
    axi_addr_t got;
    logic [8:0] idx;
    if (!rst_x) begin
      rvalid_d = 1'b0;
    end else begin
      // B and R are never back-pressured
      if (i_bready !== 1'b1) report_mismatch("o_bready", 64'(i_bready), 64'(1'b1));
      if (i_rready !== 1'b1) report_mismatch("o_rready", 64'(i_rready), 64'(1'b1));
      if (i_brg_req && i_brg_ack) cmd_q.push_back(i_brg_cmd);
      if (i_brg_wdvalid && i_brg_wack) wd_q.push_back(i_brg_wdat);
      // requests leave in command order
      if (i_aw_hs || i_ar_hs) begin
        if (cmd_q.size() == 0) begin
          report_error("address request issued with no command pending");
        end else begin
          c = cmd_q.pop_front();
          got = i_aw_hs ? i_aw : i_ar;
          if (c.rw != i_aw_hs) report_error("address request on the wrong channel");
          if (got !== expected_req(c)) begin
            report_mismatch(i_aw_hs ? "o_aw" : "o_ar", 64'(got), 64'(expected_req(c)));
          end
          if (c.rw) begin
            aw_cnt++;
            cur_w  = c;
            w_beat = 0;
          end else begin
            ar_cnt++;
            for (int k = 0; k < int'(c.len); k++) begin
              rd_q.push_back(expected_beat(c, k));
            end
          end
        end
      end
      // W beats in data order, shadow updated as they go
      if (i_w_hs) begin
        if (wd_q.size() == 0) begin
          report_error("W beat with no write data sent");
        end else begin
          wd = wd_q.pop_front();
          ew.id   = {2'b00, cur_w.id};
          ew.data = wd.data;
          ew.strb = wd.be;
          ew.last = (w_beat == int'(cur_w.len) - 1);
          if (i_w !== ew) report_mismatch("o_w", 64'(i_w), 64'(ew));
          idx = 9'(cur_w.addr) + 9'(w_beat);
          shadow[idx] = merge_bytes(shadow[idx], wd);
          if (ew.last) wlast_cnt++;
          w_beat++;
        end
      end
      // return is one cycle behind R
      if (i_brg_rdvalid !== rvalid_d) begin
        report_error("read return not exactly one cycle after its R beat");
      end
      if (i_brg_rdvalid) begin
        if (rd_q.size() == 0) begin
          report_error("read beat returned with no read outstanding");
        end else begin
          er = rd_q.pop_front();
          if (i_brg_rdat !== er) report_mismatch("o_brg_rdat", 64'(i_brg_rdat), 64'(er));
        end
      end
      rvalid_d = i_rvalid;
    end
    busy = (cmd_q.size() != 0) || (wd_q.size() != 0) || (rd_q.size() != 0);
  end

  initial begin
    for (int a = 0; a < 512; a++) begin
      shadow[9'(a)] = fill_word(a);
    end
  end

  assign o_err_cnt   = err_cnt;
  assign o_aw_cnt    = aw_cnt;
  assign o_wlast_cnt = wlast_cnt;
  assign o_ar_cnt    = ar_cnt;
  assign o_busy      = busy;

endmodule

/* test/tb_axi_bridge.sv */
// bridge testbench, clock, reset, stimulus, AXI slave memory, watchdog, DUT, checker
module tb_axi_bridge;
  import brg_pkg::*;
  import axi_pkg::*;

  // every test beat gets 40 cycles, plus reset and drain margin
  localparam int TOTAL_BEATS = 4 + 3 + 4 + 4 + 200 * 16;
  localparam int WDOG_CYCLES = TOTAL_BEATS * 40 + 2000;
  localparam int MEM_WORDS   = 512;

  logic clk_core = 1'b0;
  logic rst_x;
  logic i_brg_req, i_brg_wdvalid, o_brg_ack, o_brg_wack, o_brg_rdvalid;
  brg_cmd_t  i_brg_cmd;
  brg_wdat_t i_brg_wdat;
  brg_rdat_t o_brg_rdat;
  logic o_awvalid, o_wvalid, o_arvalid, o_bready, o_rready;
  axi_addr_t o_aw;
  axi_addr_t o_ar;
  axi_w_t    o_w;
  logic   i_awready = 1'b1;
  logic   i_wready = 1'b1;
  logic   i_arready = 1'b1;
  logic   i_bvalid = 1'b0;
  logic   i_rvalid = 1'b0;
  axi_r_t i_r = '0;
  // checker results
  int   chk_errs, aw_cnt, wlast_cnt, ar_cnt;
  logic chk_busy;
  // slave model state
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] seed = 32'h1adeca6f;
  logic        stall_en = 1'b0;
  logic        b_hold = 1'b0;
  logic [8:0]  w_idx = '0;
  int          cycle = 0;
  int          b_due_q[$];
  axi_r_t      r_q[$];
  int          tb_errs = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  // AR seen while the hazard window is open
  logic        ar_watch = 1'b0;
  logic        seen_ar = 1'b0;

  always #4 clk_core = ~clk_core;

  axi_bridge_top #(.P_WD_DEPTH(4), .P_RAW_DEPTH(4)) i_axi_bridge_top (.*);

  axi_bridge_checker u_checker (
    .clk_core      (clk_core),
    .rst_x         (rst_x),
    .i_brg_req     (i_brg_req),
    .i_brg_cmd     (i_brg_cmd),
    .i_brg_ack     (o_brg_ack),
    .i_brg_wdvalid (i_brg_wdvalid),
    .i_brg_wdat    (i_brg_wdat),
    .i_brg_wack    (o_brg_wack),
    .i_aw_hs       (o_awvalid & i_awready),
    .i_aw          (o_aw),
    .i_w_hs        (o_wvalid & i_wready),
    .i_w           (o_w),
    .i_ar_hs       (o_arvalid & i_arready),
    .i_ar          (o_ar),
    .i_rvalid      (i_rvalid),
    .i_bready      (o_bready),
    .i_rready      (o_rready),
    .i_brg_rdvalid (o_brg_rdvalid),
    .i_brg_rdat    (o_brg_rdat),
    .o_err_cnt     (chk_errs),
    .o_aw_cnt      (aw_cnt),
    .o_wlast_cnt   (wlast_cnt),
    .o_ar_cnt      (ar_cnt),
    .o_busy        (chk_busy)
  );

  // LCG, upper half is the better half
  function automatic logic [31:0] rnd();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {16'h0, seed[31:16]};
  endfunction

  function automatic logic [31:0] fill_word(input int a);
    return 32'hc3a50000 ^ (32'(a) * 32'h00010003);
  endfunction

  //////////////////////////////////////////////////
  // AXI slave memory model
  //////////////////////////////////////////////////
  // handshakes seen at the rising edge
  always @(posedge clk_core) begin
    logic [8:0] a;
    axi_r_t     rb;
    cycle++;
    if (o_awvalid && i_awready) w_idx = o_aw.addr[10:2];
    if (o_wvalid && i_wready) begin
      for (int b = 0; b < 4; b++) begin
        if (o_w.strb[b]) mem[w_idx][8*b +: 8] = o_w.data[8*b +: 8];
      end
      w_idx = w_idx + 9'd1;
      if (o_w.last) b_due_q.push_back(cycle + (stall_en ? int'(rnd() % 8) : 2));
    end
    // read data captured at AR time
    if (o_arvalid && i_arready) begin
      a = o_ar.addr[10:2];
      for (int k = 0; k <= int'(o_ar.len); k++) begin
        rb.id   = o_ar.id;
        rb.data = mem[a + 9'(k)];
        rb.last = (k == int'(o_ar.len));
        r_q.push_back(rb);
      end
    end
  end

  // responses and ready stalls on the falling edge
  always @(negedge clk_core) begin
    if (rst_x) begin
      i_awready = !stall_en || (rnd() % 4 != 0);
      i_wready  = !stall_en || (rnd() % 4 != 0);
      i_arready = !stall_en || (rnd() % 4 != 0);
      i_bvalid  = 1'b0;
      if (!b_hold && b_due_q.size() != 0 && cycle >= b_due_q[0]) begin
        i_bvalid = 1'b1;
        void'(b_due_q.pop_front());
      end
      i_rvalid = 1'b0;
      if (r_q.size() != 0 && (!stall_en || rnd() % 4 != 0)) begin
        i_r      = r_q.pop_front();
        i_rvalid = 1'b1;
      end
    end
  end

  // AR stays up at least until the next rising edge, so the falling edge sees it
  always @(negedge clk_core) begin
    if (ar_watch && o_arvalid) seen_ar = 1'b1;
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////
  task automatic send_cmd(input logic rw, input logic [29:0] addr, input int len,
                          input logic [1:0] id);
    while (!o_brg_ack) @(negedge clk_core);
    i_brg_cmd.id   = id;
    i_brg_cmd.rw   = rw;
    i_brg_cmd.addr = addr;
    i_brg_cmd.len  = 6'(len);
    i_brg_req      = 1'b1;
    @(negedge clk_core);
    i_brg_req = 1'b0;
  endtask

  // command, then its beats with random data and strobes
  task automatic send_write(input logic [29:0] addr, input int len, input logic [1:0] id);
    logic [31:0] hi;
    logic [31:0] lo;
    send_cmd(1'b1, addr, len, id);
    for (int k = 0; k < len; k++) begin
      while (!o_brg_wack) @(negedge clk_core);
      i_brg_wdat.be   = 4'(rnd());
      hi = rnd();
      lo = rnd();
      i_brg_wdat.data = {hi[15:0], lo[15:0]};
      i_brg_wdvalid   = 1'b1;
      @(negedge clk_core);
      i_brg_wdvalid = 1'b0;
    end
  endtask

  task automatic wait_idle(input logic with_b, input string what);
    int n;
    n = 0;
    while ((chk_busy || r_q.size() != 0 || (with_b && b_due_q.size() != 0)) && n < 3000) begin
      @(negedge clk_core);
      n++;
    end
    if (n >= 3000) begin
      $display("ERROR: %s at %0t", what, $time);
      tb_errs++;
    end
    @(negedge clk_core);
  endtask

  function automatic int total_errors();
    return chk_errs + tb_errs;
  endfunction

  task automatic report_test(input int num, input string name, input int start);
    tests_run++;
    if (total_errors() == start) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, total_errors() - start);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////
  initial begin
    int          start;
    int          aw0, wl0, ar0, nw, nr;
    logic [31:0] r;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[9'(a)] = fill_word(a);
    end
    i_brg_req     = 1'b0;
    i_brg_cmd     = '0;
    i_brg_wdvalid = 1'b0;
    i_brg_wdat    = '0;
    rst_x         = 1'b0;
    repeat (5) @(posedge clk_core);
    @(negedge clk_core);
    rst_x = 1'b1;
    @(negedge clk_core);

    start = total_errors();
    send_write(30'h10, 4, 2'd1);
    wait_idle(1'b1, "write burst did not complete");
    report_test(1, "single write burst", start);

    start = total_errors();
    send_cmd(1'b0, 30'h10, 3, 2'd2);
    wait_idle(1'b1, "read burst did not complete");
    report_test(2, "single read burst", start);

    // read of the same address must wait for B
    start = total_errors();
    b_hold = 1'b1;
    send_write(30'h40, 2, 2'd3);
    seen_ar  = 1'b0;
    ar_watch = 1'b1;
    send_cmd(1'b0, 30'h40, 2, 2'd1);
    repeat (40) @(negedge clk_core);
    ar_watch = 1'b0;
    if (seen_ar) begin
      $display("ERROR: AR issued while a write to the same address awaited its B");
      tb_errs++;
    end
    b_hold = 1'b0;
    wait_idle(1'b1, "hazard read did not complete after B release");
    report_test(3, "read after write hazard", start);

    // unrelated read passes a held write
    start = total_errors();
    b_hold = 1'b1;
    send_write(30'h60, 2, 2'd0);
    send_cmd(1'b0, 30'h90, 2, 2'd2);
    wait_idle(1'b0, "read to an unrelated address stalled behind a held write response");
    b_hold = 1'b0;
    wait_idle(1'b1, "held write response never retired");
    report_test(4, "independent read during held B", start);

    start = total_errors();
    stall_en = 1'b1;
    aw0 = aw_cnt;
    wl0 = wlast_cnt;
    ar0 = ar_cnt;
    nw  = 0;
    nr  = 0;
    for (int i = 0; i < 200; i++) begin
      r = rnd();
      if (r[0]) begin
        send_write(30'(r[15:8]), 1 + int'(r[7:4]), r[2:1]);
        nw++;
      end else begin
        send_cmd(1'b0, 30'(r[15:8]), 1 + int'(r[7:4]), r[2:1]);
        nr++;
      end
    end
    wait_idle(1'b1, "random traffic did not drain");
    stall_en = 1'b0;
    if (aw_cnt - aw0 != nw || wlast_cnt - wl0 != nw || ar_cnt - ar0 != nr) begin
      $display("ERROR: saw %0d AW, %0d W last, %0d AR for %0d writes and %0d reads sent",
               aw_cnt - aw0, wlast_cnt - wl0, ar_cnt - ar0, nw, nr);
      tb_errs++;
    end
    report_test(5, "random mix with stalls", start);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk_core);
    $display("ERROR: watchdog expired after %0d cycles, the bridge stopped making progress",
             WDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
